/* design/axis2m_bridge.sv */
`timescale 1ns/1ns

module axis2m_bridge (
  input  logic        axis_aclk,
  input  logic        axis_areset,
  input  logic [7:0]  s_tdata,
  input  logic        s_tvalid,
  input  logic        s_tlast,
  output logic        s_tready,
  output logic [7:0]  m_tdata,
  output logic        m_tvalid,
  output logic        m_tlast,
  input  logic        m_tready,
  input  logic        reset_status,
  input  logic        clock_status,
  output logic [1:0]  awburst,
  output logic [7:0]  awlen,
  output logic [63:0] waddr,
  output logic [7:0]  wdata,
  output logic        wdatav,
  output logic        wstart,
  input  logic        wresp
);

  logic burst_load;
  logic addr_shift;
  logic len_load;
  logic data_take;
  logic write_busy;
  logic version_req;
  logic write_done;

  cmd_parser cmd_parser_i (
    .axis_aclk   (axis_aclk),
    .axis_areset (axis_areset),
    .s_tdata     (s_tdata),
    .s_tvalid    (s_tvalid),
    .s_tlast     (s_tlast),
    .s_tready    (s_tready),
    .write_done  (write_done),
    .burst_load  (burst_load),
    .addr_shift  (addr_shift),
    .len_load    (len_load),
    .data_take   (data_take),
    .write_busy  (write_busy),
    .version_req (version_req)
  );

  write_capture write_capture_i (
    .axis_aclk   (axis_aclk),
    .axis_areset (axis_areset),
    .s_tdata     (s_tdata),
    .burst_load  (burst_load),
    .addr_shift  (addr_shift),
    .len_load    (len_load),
    .data_take   (data_take),
    .write_busy  (write_busy),
    .awburst     (awburst),
    .awlen       (awlen),
    .waddr       (waddr),
    .wdata       (wdata),
    .wdatav      (wdatav),
    .wstart      (wstart)
  );

  // reply path back to the host
  reply_gen reply_gen_i (
    .axis_aclk    (axis_aclk),
    .axis_areset  (axis_areset),
    .version_req  (version_req),
    .wresp        (wresp),
    .write_done   (write_done),
    .m_tdata      (m_tdata),
    .m_tvalid     (m_tvalid),
    .m_tlast      (m_tlast),
    .m_tready     (m_tready),
    .reset_status (reset_status),
    .clock_status (clock_status)
  );

endmodule

/* design/axis2m_pkg.sv */
package axis2m_pkg;

  // command opcodes on the slave stream
  localparam logic [7:0] op_get_version = 8'h83;
  localparam logic [7:0] op_write_cfg1  = 8'h84;
  localparam logic [7:0] op_write_cfg2  = 8'h85;

  // reply constants
  localparam logic [7:0] reply_write_ack  = 8'h84;
  localparam logic [7:0] version_len_byte = 8'd5;

  // identification and capability flags
  localparam logic [31:0] ip_id    = 32'h4158_4d31;
  localparam logic        data_64  = 1'b0;
  localparam logic        addrs_64 = 1'b1;

  localparam int addr_bytes          = 8;
  localparam int version_reply_bytes = 7;

  // reply sequencer states
  localparam logic [1:0] rs_idle    = 2'd0;
  localparam logic [1:0] rs_version = 2'd1;
  localparam logic [1:0] rs_ack     = 2'd2;

  // first byte of a packet, low bit doubles as burst select
  typedef union packed {
    logic [7:0] raw;
    struct packed {
      logic [6:0] opcode_hi;
      logic       burst_sel;
    } fields;
  } cmd_byte_u;

  typedef enum logic [3:0] {
    idle    = 4'd0,
    decode  = 4'd1,
    version = 4'd2,
    drain   = 4'd3,
    wr_cmd  = 4'd4,
    wr_addr = 4'd5,
    wr_len  = 4'd6,
    wr_data = 4'd7,
    wr_resp = 4'd8
  } parse_state_e;

endpackage

/* design/cmd_parser.sv */
`timescale 1ns/1ns

module cmd_parser (
  input  logic       axis_aclk,
  input  logic       axis_areset,
  input  logic [7:0] s_tdata,
  input  logic       s_tvalid,
  input  logic       s_tlast,
  output logic       s_tready,
  input  logic       write_done,
  output logic       burst_load,
  output logic       addr_shift,
  output logic       len_load,
  output logic       data_take,
  output logic       write_busy,
  output logic       version_req
);

  import axis2m_pkg::*;

  parse_state_e state;
  cmd_byte_u    cmd;
  logic         xfer;
  logic         first_byte;
  logic [2:0]   addr_cnt;

  assign cmd.raw = s_tdata;
  assign xfer    = s_tvalid && s_tready;

  always_ff @(posedge axis_aclk) begin
    if (axis_areset) begin
      state    <= idle;
      s_tready <= 1'b0;
    end else begin
      case (state)
        idle: begin
          s_tready <= 1'b0;
          if (s_tvalid) begin
            state <= decode;
          end
        end
        // peek at the held first byte, ready opens next cycle
        decode: begin
          s_tready <= 1'b1;
          case (cmd.raw)
            op_get_version: state <= version;
            op_write_cfg1,
            op_write_cfg2:  state <= wr_cmd;
            default:        state <= drain;
          endcase
        end
        version,
        drain: begin
          if (xfer && s_tlast) begin
            s_tready <= 1'b0;
            state    <= idle;
          end
        end
        wr_cmd: begin
          s_tready <= 1'b1;
          if (xfer) begin
            state <= wr_addr;
          end
        end
        wr_addr: begin
          if (xfer && (addr_cnt == 3'(addr_bytes - 1))) begin
            state <= wr_len;
          end
        end
        wr_len: begin
          if (xfer) begin
            s_tready <= 1'b0;
            state    <= wr_data;
          end
        end
        wr_data: begin
          if (xfer && s_tlast) begin
            s_tready <= 1'b0;
            state    <= wr_resp;
          end else begin
            s_tready <= 1'b1;
          end
        end
        // hold off input until the engine answers
        wr_resp: begin
          s_tready <= 1'b0;
          if (write_done) begin
            state <= idle;
          end
        end
        default: begin
          s_tready <= 1'b0;
          state    <= idle;
        end
      endcase
    end
  end

  // address byte counter, wraps back to zero after the eighth byte
  always_ff @(posedge axis_aclk) begin
    if (axis_areset) begin
      addr_cnt <= 3'd0;
    end else if (state == decode) begin
      addr_cnt <= 3'd0;
    end else if (addr_shift) begin
      addr_cnt <= addr_cnt + 3'd1;
    end
  end

  // marks the opcode byte of a version packet
  always_ff @(posedge axis_aclk) begin
    if (axis_areset) begin
      first_byte  <= 1'b0;
      version_req <= 1'b0;
    end else begin
      version_req <= (state == version) && xfer && first_byte;
      if (state == decode) begin
        first_byte <= 1'b1;
      end else if (xfer) begin
        first_byte <= 1'b0;
      end
    end
  end

  assign burst_load = (state == wr_cmd) && xfer;
  assign addr_shift = (state == wr_addr) && xfer;
  assign len_load   = (state == wr_len) && xfer;
  assign data_take  = (state == wr_data) && xfer;
  assign write_busy = state inside {wr_cmd, wr_addr, wr_len, wr_data, wr_resp};

endmodule

/* design/reply_gen.sv */
`timescale 1ns/1ns

module reply_gen (
  input  logic       axis_aclk,
  input  logic       axis_areset,
  input  logic       version_req,
  input  logic       wresp,
  output logic       write_done,
  output logic [7:0] m_tdata,
  output logic       m_tvalid,
  output logic       m_tlast,
  input  logic       m_tready,
  input  logic       reset_status,
  input  logic       clock_status
);

  import axis2m_pkg::*;

  logic [1:0]  rs_state;
  logic        wresp_d1;
  logic        ver_pend;
  logic        ack_pend;
  logic        start_ver;
  logic        start_ack;
  logic        out_xfer;
  logic        ver_valid;
  logic        ver_last;
  logic [2:0]  byte_cnt;
  logic [55:0] ver_shift;

  // wresp rising edge
  always_ff @(posedge axis_aclk) begin
    if (axis_areset) begin
      wresp_d1   <= 1'b0;
      write_done <= 1'b0;
    end else begin
      wresp_d1   <= wresp;
      write_done <= wresp && !wresp_d1;
    end
  end

  assign out_xfer  = m_tvalid && m_tready;
  assign start_ver = (rs_state == rs_idle) && (ver_pend || version_req);
  assign start_ack = (rs_state == rs_idle) && !start_ver && (ack_pend || write_done);

  // requests wait here while another reply is going out
  always_ff @(posedge axis_aclk) begin
    if (axis_areset) begin
      ver_pend <= 1'b0;
      ack_pend <= 1'b0;
    end else begin
      if (start_ver) begin
        ver_pend <= 1'b0;
      end else if (version_req) begin
        ver_pend <= 1'b1;
      end
      if (start_ack) begin
        ack_pend <= 1'b0;
      end else if (write_done) begin
        ack_pend <= 1'b1;
      end
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (axis_areset) begin
      rs_state <= rs_idle;
    end else if (start_ver) begin
      rs_state <= rs_version;
    end else if (start_ack) begin
      rs_state <= rs_ack;
    end else if (out_xfer && m_tlast) begin
      rs_state <= rs_idle;
    end
  end

  // version reply shifter, reloaded every idle cycle
  always_ff @(posedge axis_aclk) begin
    if (rs_state == rs_idle) begin
      ver_shift <= {op_get_version, version_len_byte, ip_id,
                    4'b0000, reset_status, clock_status, data_64, addrs_64};
    end else if (out_xfer) begin
      ver_shift <= {ver_shift[47:0], 8'h00};
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (axis_areset) begin
      byte_cnt  <= 3'd0;
      ver_valid <= 1'b0;
    end else if (rs_state != rs_version) begin
      byte_cnt  <= 3'd0;
      ver_valid <= 1'b0;
    end else if (out_xfer && ver_last) begin
      ver_valid <= 1'b0;
    end else begin
      ver_valid <= 1'b1;
      if (out_xfer) begin
        byte_cnt <= byte_cnt + 3'd1;
      end
    end
  end

  assign ver_last = ver_valid && (byte_cnt == 3'(version_reply_bytes - 1));

  always_comb begin
    case (rs_state)
      rs_version: begin
        m_tvalid = ver_valid;
        m_tdata  = ver_shift[55:48];
        m_tlast  = ver_last;
      end
      // single byte acknowledge
      rs_ack: begin
        m_tvalid = 1'b1;
        m_tdata  = reply_write_ack;
        m_tlast  = 1'b1;
      end
      default: begin
        m_tvalid = 1'b0;
        m_tdata  = 8'h00;
        m_tlast  = 1'b0;
      end
    endcase
  end

endmodule

/* design/write_capture.sv */
`timescale 1ns/1ns

module write_capture (
  input  logic        axis_aclk,
  input  logic        axis_areset,
  input  logic [7:0]  s_tdata,
  input  logic        burst_load,
  input  logic        addr_shift,
  input  logic        len_load,
  input  logic        data_take,
  input  logic        write_busy,
  output logic [1:0]  awburst,
  output logic [7:0]  awlen,
  output logic [63:0] waddr,
  output logic [7:0]  wdata,
  output logic        wdatav,
  output logic        wstart
);

  import axis2m_pkg::*;

  cmd_byte_u cmd;
  logic      data_seen;

  assign cmd.raw = s_tdata;

  // write configuration registers
  always_ff @(posedge axis_aclk) begin
    if (burst_load) begin
      awburst <= {1'b0, cmd.fields.burst_sel};
    end
    if (len_load) begin
      awlen <= s_tdata;
    end
    // first byte received ends up in the low byte
    if (addr_shift) begin
      waddr <= {s_tdata, waddr[63:8]};
    end
    if (data_take) begin
      wdata <= s_tdata;
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (axis_areset) begin
      wdatav <= 1'b0;
    end else begin
      wdatav <= data_take;
    end
  end

  // start the engine once the data bytes stop coming
  always_ff @(posedge axis_aclk) begin
    if (axis_areset) begin
      data_seen <= 1'b0;
      wstart    <= 1'b0;
    end else if (!write_busy) begin
      data_seen <= 1'b0;
      wstart    <= 1'b0;
    end else begin
      if (data_take) begin
        data_seen <= 1'b1;
      end
      if (data_seen && !data_take) begin
        wstart <= 1'b1;
      end
    end
  end

endmodule

/* run.sh */
#!/bin/sh
# build with Verilator, run, and judge the result from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
  --top-module tb_axis2m_bridge -f sim.f -o sim_tb &&
  ./obj_dir/sim_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^TEST PASS$" sim.log 2>/dev/null && echo "simulation passed" || {
  echo "simulation failed"
  exit 1
}

/* sim.f */
design/axis2m_pkg.sv
design/cmd_parser.sv
design/write_capture.sv
design/reply_gen.sv
design/axis2m_bridge.sv
tests/tb_axis2m_bridge.sv

/* tests/tb_axis2m_bridge.sv */
`timescale 1ns/1ns

module tb_axis2m_bridge;

  import axis2m_pkg::*;

  localparam int clk_period = 4;
  // input bytes plus reply bytes over all tests
  localparam int packet_bytes = 47;
  localparam int watchdog_ns  = (packet_bytes * 10 + 20) * clk_period;

  logic        axis_aclk = 1'b0;
  logic        axis_areset;
  logic [7:0]  s_tdata;
  logic        s_tvalid;
  logic        s_tlast;
  logic        s_tready;
  logic [7:0]  m_tdata;
  logic        m_tvalid;
  logic        m_tlast;
  logic        m_tready;
  logic        reset_status;
  logic        clock_status;
  logic [1:0]  awburst;
  logic [7:0]  awlen;
  logic [63:0] waddr;
  logic [7:0]  wdata;
  logic        wdatav;
  logic        wstart;
  logic        wresp;

  logic [7:0]  exp_reply [0:31];
  logic        exp_reply_last [0:31];
  logic [4:0]  wr_ptr;
  logic [4:0]  rd_ptr;
  logic [7:0]  exp_byte;
  logic        exp_last;
  logic [7:0]  exp_wdata [0:15];
  logic [3:0]  wd_total;
  logic [3:0]  wd_ptr;
  logic [7:0]  exp_wbyte;
  logic [1:0]  exp_burst;
  logic [7:0]  exp_len;
  logic [63:0] exp_addr;
  logic        wresp_seen;
  logic [4:0]  out_flags;

  integer      seed;
  logic [31:0] rnd;
  logic [7:0]  pool [0:63];
  logic [5:0]  pool_idx;

  axis2m_bridge axis2m_bridge_i (
    .axis_aclk    (axis_aclk),
    .axis_areset  (axis_areset),
    .s_tdata      (s_tdata),
    .s_tvalid     (s_tvalid),
    .s_tlast      (s_tlast),
    .s_tready     (s_tready),
    .m_tdata      (m_tdata),
    .m_tvalid     (m_tvalid),
    .m_tlast      (m_tlast),
    .m_tready     (m_tready),
    .reset_status (reset_status),
    .clock_status (clock_status),
    .awburst      (awburst),
    .awlen        (awlen),
    .waddr        (waddr),
    .wdata        (wdata),
    .wdatav       (wdatav),
    .wstart       (wstart),
    .wresp        (wresp)
  );

  always #2 axis_aclk = ~axis_aclk;

  assign exp_byte  = exp_reply[rd_ptr];
  assign exp_last  = exp_reply_last[rd_ptr];
  assign exp_wbyte = exp_wdata[wd_ptr];
  assign out_flags = {s_tready, m_tvalid, m_tlast, wdatav, wstart};

  // fill the byte pool first and then randomise m_tready every cycle
  initial begin
    seed     = 32'h98d6_872e;
    m_tready = 1'b0;
    for (int i = 0; i < 64; i++) begin
      rnd           = $random(seed);
      pool[6'(i)]   = rnd[7:0];
    end
    forever begin
      @(posedge axis_aclk);
      #1;
      rnd      = $random(seed);
      m_tready = (rnd[1:0] != 2'b00);
    end
  end

  // stub engine answers a few cycles after the start strobe
  initial begin
    wresp      = 1'b0;
    wresp_seen = 1'b0;
    forever begin
      @(posedge axis_aclk);
      if (wstart && !wresp) begin
        wresp_seen = 1'b0;
        repeat (3) @(posedge axis_aclk);
        #1;
        wresp      = 1'b1;
        wresp_seen = 1'b1;
        do begin
          @(posedge axis_aclk);
        end while (wstart);
        #1;
        wresp = 1'b0;
      end
    end
  end

  always @(posedge axis_aclk) begin
    if (axis_areset) begin
      rd_ptr <= 5'd0;
      wd_ptr <= 4'd0;
    end else begin
      if (m_tvalid && m_tready) begin
        rd_ptr <= rd_ptr + 5'd1;
      end
      if (wdatav) begin
        wd_ptr <= wd_ptr + 4'd1;
      end
    end
  end

  reset_chk: assert property (@(posedge axis_aclk)
      $fell(axis_areset) |-> (out_flags == 5'b00000))
    else fail_now($sformatf(
      "[FAIL] %0t {s_tready,m_tvalid,m_tlast,wdatav,wstart} expected %b got %b",
      $time, 5'b00000, $sampled(out_flags)));

  reply_expected_chk: assert property (@(posedge axis_aclk) disable iff (axis_areset)
      (m_tvalid && m_tready) |-> (rd_ptr != wr_ptr))
    else fail_now("a reply byte was sent while no reply was expected");

  reply_data_chk: assert property (@(posedge axis_aclk) disable iff (axis_areset)
      (m_tvalid && m_tready) |-> (m_tdata == exp_byte))
    else fail_now($sformatf("[FAIL] %0t m_tdata expected %h got %h",
      $time, $sampled(exp_byte), $sampled(m_tdata)));

  reply_last_chk: assert property (@(posedge axis_aclk) disable iff (axis_areset)
      (m_tvalid && m_tready) |-> (m_tlast == exp_last))
    else fail_now($sformatf("[FAIL] %0t m_tlast expected %b got %b",
      $time, $sampled(exp_last), $sampled(m_tlast)));

  // stalled reply must not change
  reply_hold_chk: assert property (@(posedge axis_aclk) disable iff (axis_areset)
      (m_tvalid && !m_tready) |=> (m_tvalid && $stable(m_tdata) && $stable(m_tlast)))
    else fail_now("the reply stream changed while m_tready was low");

  ack_order_chk: assert property (@(posedge axis_aclk) disable iff (axis_areset)
      (m_tvalid && m_tready && m_tlast && m_tdata == 8'h84) |-> wresp_seen)
    else fail_now("the write acknowledge was sent before the engine gave wresp");

  wdatav_expected_chk: assert property (@(posedge axis_aclk) disable iff (axis_areset)
      wdatav |-> (wd_ptr != wd_total))
    else fail_now("wdatav pulsed while no write data byte was expected");

  wdata_chk: assert property (@(posedge axis_aclk) disable iff (axis_areset)
      wdatav |-> (wdata == exp_wbyte))
    else fail_now($sformatf("[FAIL] %0t wdata expected %h got %h",
      $time, $sampled(exp_wbyte), $sampled(wdata)));

  wstart_count_chk: assert property (@(posedge axis_aclk) disable iff (axis_areset)
      $rose(wstart) |-> (wd_ptr == wd_total))
    else fail_now($sformatf("[FAIL] %0t wdatav pulse count expected %0d got %0d",
      $time, $sampled(wd_total), $sampled(wd_ptr)));

  awburst_chk: assert property (@(posedge axis_aclk) disable iff (axis_areset)
      $rose(wstart) |-> (awburst == exp_burst))
    else fail_now($sformatf("[FAIL] %0t awburst expected %h got %h",
      $time, $sampled(exp_burst), $sampled(awburst)));

  awlen_chk: assert property (@(posedge axis_aclk) disable iff (axis_areset)
      $rose(wstart) |-> (awlen == exp_len))
    else fail_now($sformatf("[FAIL] %0t awlen expected %h got %h",
      $time, $sampled(exp_len), $sampled(awlen)));

  waddr_chk: assert property (@(posedge axis_aclk) disable iff (axis_areset)
      $rose(wstart) |-> (waddr == exp_addr))
    else fail_now($sformatf("[FAIL] %0t waddr expected %h got %h",
      $time, $sampled(exp_addr), $sampled(waddr)));

  wstart_fall_chk: assert property (@(posedge axis_aclk) disable iff (axis_areset)
      $fell(wstart) |-> wresp)
    else fail_now("wstart fell before the engine raised wresp");

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  function automatic logic [7:0] next_rand();
    next_rand = pool[pool_idx];
    pool_idx  = pool_idx + 6'd1;
  endfunction

  task automatic expect_reply(input logic [7:0] b, input logic last);
    exp_reply[wr_ptr]      = b;
    exp_reply_last[wr_ptr] = last;
    wr_ptr                 = wr_ptr + 5'd1;
  endtask

  task automatic send_byte(input logic [7:0] b, input logic last);
    s_tdata  = b;
    s_tvalid = 1'b1;
    s_tlast  = last;
    do begin
      @(posedge axis_aclk);
    end while (!s_tready);
    #1;
  endtask

  task automatic end_packet();
    s_tvalid = 1'b0;
    s_tlast  = 1'b0;
  endtask

  // replies drained and engine handshake finished
  task automatic wait_done();
    do begin
      @(posedge axis_aclk);
    end while ((rd_ptr != wr_ptr) || wstart || wresp);
    repeat (2) @(posedge axis_aclk);
    #1;
  endtask

  task automatic version_test(input logic rs, input logic cs);
    reset_status = rs;
    clock_status = cs;
    expect_reply(8'h83, 1'b0);
    expect_reply(8'h05, 1'b0);
    for (int i = 3; i >= 0; i--) begin
      expect_reply(ip_id[8*i +: 8], 1'b0);
    end
    expect_reply({4'b0000, rs, cs, data_64, addrs_64}, 1'b1);
    send_byte(8'h83, 1'b1);
    end_packet();
    wait_done();
  endtask

  task automatic write_test(input logic [7:0] opcode, input logic [1:0] burst,
                            input int ndata);
    logic [7:0] b;
    exp_burst = burst;
    exp_len   = 8'(ndata - 1);
    expect_reply(8'h84, 1'b1);
    send_byte(opcode, 1'b0);
    // first address byte is the least significant
    for (int i = 0; i < addr_bytes; i++) begin
      b                  = next_rand();
      exp_addr[8*i +: 8] = b;
      send_byte(b, 1'b0);
    end
    send_byte(exp_len, 1'b0);
    for (int i = 0; i < ndata; i++) begin
      b                   = next_rand();
      exp_wdata[wd_total] = b;
      wd_total            = wd_total + 4'd1;
      send_byte(b, i == ndata - 1);
    end
    end_packet();
    wait_done();
  endtask

  task automatic unknown_test(input logic [7:0] opcode, input int nbytes);
    send_byte(opcode, nbytes == 1);
    for (int i = 1; i < nbytes; i++) begin
      send_byte(next_rand(), i == nbytes - 1);
    end
    end_packet();
    // leave room for a wrong reply to show up
    repeat (12) @(posedge axis_aclk);
    #1;
  endtask

  initial begin
    axis_areset  = 1'b1;
    s_tdata      = 8'h00;
    s_tvalid     = 1'b0;
    s_tlast      = 1'b0;
    reset_status = 1'b0;
    clock_status = 1'b0;
    wr_ptr       = 5'd0;
    wd_total     = 4'd0;
    exp_burst    = 2'b00;
    exp_len      = 8'h00;
    exp_addr     = 64'h0;
    pool_idx     = 6'd0;
    repeat (3) @(posedge axis_aclk);
    #1;
    axis_areset = 1'b0;
    repeat (2) @(posedge axis_aclk);
    #1;
    version_test(1'b1, 1'b0);
    write_test(8'h85, 2'b01, 4);
    write_test(8'h84, 2'b00, 2);
    unknown_test(8'h42, 3);
    version_test(1'b0, 1'b1);
    if ((rd_ptr == wr_ptr) && (wd_ptr == wd_total)) begin
      $display("TEST PASS");
      $finish;
    end else begin
      fail_now("tests ended with replies or write data still outstanding");
    end
  end

  initial begin
    #(watchdog_ns);
    fail_now("timeout, the tests did not finish in the expected time");
  end

endmodule
